// File: build.f
design/mem_test_pkg.sv
design/lfsr8.sv
design/pattern_gen.sv
design/seq_addr_gen.sv
design/test_ctrl.sv
design/rdata_checker.sv
design/mem_test_driver.sv
verif/tb_mem_model.sv
verif/tb_mem_test_driver.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mem_test_driver -f build.f

out=$(./obj_dir/Vtb_mem_test_driver)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'All tests passed'; then
  exit 0
fi
exit 1

// File: verif/tb_mem_test_driver.sv
// memory test driver testbench

`timescale 1ns/1ps

module tb_mem_test_driver;

  localparam int MAX_COL      = 16;
  localparam int MAX_ROW      = 3;
  localparam int MAX_BANK     = 3;
  localparam int COL_STEP     = 4;
  localparam int COLS_PER_ROW = MAX_COL / COL_STEP + 1;
  localparam int BURSTS       = COLS_PER_ROW * (MAX_ROW + 1) * (MAX_BANK + 1);
  localparam int BEATS        = BURSTS * mem_test_pkg::BURST_LEN;
  // read beat 37 of the second pass
  localparam int CORRUPT_BEAT = BEATS + 37;
  localparam int PASS_TIMEOUT = 4000;
  localparam int DRAIN_LIMIT  = 50;

  logic                     clk;
  logic                     reset_n;
  logic                     local_ready;
  logic                     local_rdata_valid;
  mem_test_pkg::data_t      local_rdata;
  logic                     local_write_req;
  logic                     local_read_req;
  logic                     local_burstbegin;
  mem_test_pkg::bank_t      local_bank_addr;
  mem_test_pkg::row_t       local_row_addr;
  mem_test_pkg::col_t       local_col_addr;
  logic                     local_cs_addr;
  logic [2:0]               local_size;
  mem_test_pkg::lane_mask_t local_be;
  mem_test_pkg::data_t      local_wdata;
  mem_test_pkg::lane_mask_t pnf_per_byte;
  logic                     pnf_persist;
  logic                     test_complete;
  mem_test_pkg::mem_addr_t  local_addr;

  // monitor state
  int unsigned              cyc;
  int unsigned              wr_count;
  int unsigned              rd_cmd_count;
  int unsigned              rd_count;
  int unsigned              pass_done;
  logic                     tc_prev;
  logic                     stall_prev;
  logic [1:0]               req_prev;
  mem_test_pkg::mem_addr_t  addr_prev;
  mem_test_pkg::data_t      wdata_prev;
  logic                     any_miss;
  logic                     corrupt_seen;
  logic                     timed_out;
  int unsigned              due_q[$];
  int unsigned              beat_q[$];
  int                       errors [1:5];
  int                       checks;

  assign local_addr = {local_bank_addr, local_row_addr, local_col_addr};

  mem_test_driver #(
    .MAX_COL  (MAX_COL),
    .MAX_ROW  (MAX_ROW),
    .MAX_BANK (MAX_BANK),
    .COL_STEP (COL_STEP)
  ) i_mem_test_driver (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .local_rdata       (local_rdata),
    .local_write_req   (local_write_req),
    .local_read_req    (local_read_req),
    .local_burstbegin  (local_burstbegin),
    .local_bank_addr   (local_bank_addr),
    .local_row_addr    (local_row_addr),
    .local_col_addr    (local_col_addr),
    .local_cs_addr     (local_cs_addr),
    .local_size        (local_size),
    .local_be          (local_be),
    .local_wdata       (local_wdata),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_complete     (test_complete)
  );

  tb_mem_model #(
    .CORRUPT_BEAT (CORRUPT_BEAT)
  ) i_tb_mem_model (
    .clk         (clk),
    .reset_n     (reset_n),
    .write_req   (local_write_req),
    .read_req    (local_read_req),
    .burstbegin  (local_burstbegin),
    .addr        (local_addr),
    .wdata       (local_wdata),
    .ready       (local_ready),
    .rdata_valid (local_rdata_valid),
    .rdata       (local_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #4;
      clk = ~clk;
    end
  end

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------
  // column first, then row, then bank
  function automatic mem_test_pkg::mem_addr_t ref_addr(int unsigned burst);
    mem_test_pkg::mem_addr_t a;
    a.col  = mem_test_pkg::col_t'((burst % COLS_PER_ROW) * COL_STEP);
    a.row  = mem_test_pkg::row_t'((burst / COLS_PER_ROW) % (MAX_ROW + 1));
    a.bank = mem_test_pkg::bank_t'((burst / (COLS_PER_ROW * (MAX_ROW + 1))) % (MAX_BANK + 1));
    return a;
  endfunction

  // lane words after a number of lfsr steps from the reset seeds
  function automatic mem_test_pkg::data_t ref_word(int unsigned step);
    logic [7:0]          lane;
    mem_test_pkg::data_t w;
    for (int k = 0; k < mem_test_pkg::LANES; k++)
    begin
      lane = 8'(1 + 10 * k);
      for (int unsigned n = 0; n < step; n++)
        lane = {lane[6:0], lane[7] ^ lane[5] ^ lane[4] ^ lane[3]};
      w[k*mem_test_pkg::LANE_W +: mem_test_pkg::LANE_W] = lane;
    end
    return w;
  endfunction

  function automatic mem_test_pkg::lane_mask_t ref_mask(int unsigned beat);
    mem_test_pkg::lane_mask_t m;
    m = '1;
    if (int'(beat) == CORRUPT_BEAT)
      m[2] = 1'b0;
    return m;
  endfunction

  // ------------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------------
  task automatic check_addr(input int test, input string name,
                            input mem_test_pkg::mem_addr_t got,
                            input mem_test_pkg::mem_addr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors[test]++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_data(input int test, input string name,
                            input mem_test_pkg::data_t got, input mem_test_pkg::data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors[test]++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_lanes(input int test, input string name,
                             input mem_test_pkg::lane_mask_t got,
                             input mem_test_pkg::lane_mask_t exp);
    checks++;
    if (got !== exp)
    begin
      errors[test]++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_size(input int test, input string name,
                            input logic [2:0] got, input logic [2:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors[test]++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input int test, input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors[test]++;
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input int test, input string what,
                             input int unsigned got, input int unsigned exp);
    checks++;
    if (got != exp)
    begin
      errors[test]++;
      $display("pass %0d ended with %0d %s instead of %0d", pass_done, got, what, exp);
    end
  endtask

  task automatic check_idle_outputs();
    check_flag(1, "local_write_req", local_write_req, 1'b0);
    check_flag(1, "local_read_req", local_read_req, 1'b0);
    check_flag(1, "local_burstbegin", local_burstbegin, 1'b0);
    check_flag(1, "test_complete", test_complete, 1'b0);
    check_flag(1, "pnf_persist", pnf_persist, 1'b0);
    check_lanes(1, "pnf_per_byte", pnf_per_byte, '1);
  endtask

  // fixed command fields, two-beat bursts with every byte enabled on chip select 0
  task automatic check_command_fields();
    check_size(2, "local_size", local_size, 3'd2);
    check_lanes(2, "local_be", local_be, 4'hf);
    check_flag(2, "local_cs_addr", local_cs_addr, 1'b0);
  endtask

  task automatic report_test(input int n, input string name);
    $display("test %0d %s: %s, %0d errors", n, name, (errors[n] == 0) ? "ok" : "FAILED",
             errors[n]);
  endtask

  // ------------------------------------------------------------------------
  // waits sampled on the rising edge
  // ------------------------------------------------------------------------
  task automatic wait_for_pass(input int unsigned n);
    int unsigned c;
    c = 0;
    while (!timed_out && pass_done < n)
    begin
      @(posedge clk);
      c++;
      if (c > PASS_TIMEOUT)
      begin
        timed_out = 1'b1;
        $display("timeout: pass %0d did not complete within %0d cycles", n, PASS_TIMEOUT);
      end
    end
  endtask

  task automatic wait_results_drained();
    int unsigned c;
    c = 0;
    while (!timed_out && due_q.size() > 0)
    begin
      @(posedge clk);
      c++;
      if (c > DRAIN_LIMIT)
      begin
        timed_out = 1'b1;
        $display("timeout: checker results still pending after %0d cycles", DRAIN_LIMIT);
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // monitor sampling mid-cycle where inputs and outputs have settled
  // ------------------------------------------------------------------------
  always @(negedge clk)
  begin : monitor
    int unsigned              beat;
    int                       test;
    mem_test_pkg::lane_mask_t exp_mask;
    if (reset_n)
    begin
      cyc++;
      test = (pass_done == 0) ? 4 : 5;
      // held request while ready is low
      if (stall_prev)
      begin
        check_flag(2, "local_write_req", local_write_req, req_prev[1]);
        check_flag(2, "local_read_req", local_read_req, req_prev[0]);
        check_addr(2, "local address", local_addr, addr_prev);
        if (req_prev[1])
          check_data(3, "local_wdata", local_wdata, wdata_prev);
      end
      check_flag(2, "local_burstbegin", local_burstbegin,
                 (local_write_req && (wr_count % mem_test_pkg::BURST_LEN == 0)) ||
                 local_read_req);
      if ((local_write_req || local_read_req) && local_ready)
        check_command_fields();
      if (local_write_req && local_ready)
      begin
        check_addr(2, "local address", local_addr,
                   ref_addr((wr_count / mem_test_pkg::BURST_LEN) % BURSTS));
        check_data(3, "local_wdata", local_wdata, ref_word(wr_count));
        wr_count++;
      end
      if (local_read_req && local_ready)
      begin
        check_addr(2, "local address", local_addr, ref_addr(rd_cmd_count % BURSTS));
        rd_cmd_count++;
      end
      // checker result three cycles after its beat
      if (due_q.size() > 0 && due_q[0] == cyc)
      begin
        due_q.delete(0);
        beat     = beat_q.pop_front();
        exp_mask = ref_mask(beat);
        if (exp_mask != '1)
          any_miss = 1'b1;
        if (int'(beat) == CORRUPT_BEAT)
          corrupt_seen = 1'b1;
        check_lanes((beat < BEATS) ? 4 : 5, "pnf_per_byte", pnf_per_byte, exp_mask);
        check_flag((beat < BEATS) ? 4 : 5, "pnf_persist", pnf_persist, !any_miss);
      end
      if (local_rdata_valid)
      begin
        due_q.push_back(cyc + 3);
        beat_q.push_back(rd_count);
        rd_count++;
      end
      if (test_complete)
      begin
        if (tc_prev)
        begin
          errors[test]++;
          $display("test_complete stayed high for more than one cycle at %0t", $time);
        end
        else
        begin
          pass_done++;
          check_count(3, "write beats", wr_count, pass_done * BEATS);
          check_count(2, "read commands", rd_cmd_count, pass_done * BURSTS);
          check_count(test, "read beats", rd_count, pass_done * BEATS);
        end
      end
      tc_prev    = test_complete;
      stall_prev = (local_write_req || local_read_req) && !local_ready;
      req_prev   = {local_write_req, local_read_req};
      addr_prev  = local_addr;
      wdata_prev = local_wdata;
    end
  end

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial
  begin
    int failed;
    int total;
    void'($urandom(32'h6c65_1b76));
    reset_n      = 1'b0;
    cyc          = 0;
    wr_count     = 0;
    rd_cmd_count = 0;
    rd_count     = 0;
    pass_done    = 0;
    tc_prev      = 1'b0;
    stall_prev   = 1'b0;
    req_prev     = 2'b00;
    addr_prev    = '0;
    wdata_prev   = '0;
    any_miss     = 1'b0;
    corrupt_seen = 1'b0;
    timed_out    = 1'b0;
    checks       = 0;
    for (int i = 1; i <= 5; i++)
      errors[i] = 0;

    for (int c = 0; c < 4; c++)
    begin
      @(posedge clk);
      #1;
      check_idle_outputs();
    end
    reset_n = 1'b1;
    // controller still idle half a cycle later
    @(negedge clk);
    check_idle_outputs();
    report_test(1, "reset outputs");

    wait_for_pass(1);
    wait_results_drained();
    if (!timed_out)
      report_test(4, "faithful read-back");

    wait_for_pass(2);
    wait_results_drained();
    if (!timed_out)
    begin
      @(negedge clk);
      check_flag(5, "pnf_persist", pnf_persist, 1'b0);
      if (!corrupt_seen)
      begin
        errors[5]++;
        $display("the corrupted read beat never reached the checker");
      end
      report_test(2, "burst commands and burst_begin");
      report_test(3, "write data over two passes");
      report_test(5, "lane 2 error injection");
    end

    failed = 0;
    total  = 0;
    for (int i = 1; i <= 5; i++)
    begin
      total += errors[i];
      if (errors[i] != 0)
        failed++;
    end
    $display("5 tests, %0d failed, %0d checks, %0d errors", failed, checks, total);
    if (!timed_out && failed == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: verif/tb_mem_model.sv
// behavioral ddr2 local port memory

`timescale 1ns/1ps

module tb_mem_model #(
  parameter int CORRUPT_BEAT = -1
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    write_req,
  input  logic                    read_req,
  input  logic                    burstbegin,
  input  mem_test_pkg::mem_addr_t addr,
  input  mem_test_pkg::data_t     wdata,
  output logic                    ready,
  output logic                    rdata_valid,
  output mem_test_pkg::data_t     rdata
);

  // storage keyed by burst address and beat
  mem_test_pkg::data_t mem [int unsigned];

  int unsigned         cyc;
  int unsigned         wr_beat;
  int unsigned         rd_beats_out;
  int unsigned         last_due;
  int unsigned         due_q[$];
  mem_test_pkg::data_t data_q[$];

  function automatic int unsigned mem_key(mem_test_pkg::mem_addr_t a, int unsigned beat);
    return {6'd0, a, beat[0]};
  endfunction

  // ------------------------------------------------------------------------
  // requests seen mid-cycle, they transfer on the next rising edge
  // ------------------------------------------------------------------------
  task automatic accept_requests();
    int unsigned         due;
    int unsigned         key;
    mem_test_pkg::data_t word;
    if (write_req && ready)
    begin
      if (burstbegin)
        wr_beat = 0;
      mem[mem_key(addr, wr_beat)] = wdata;
      wr_beat++;
    end
    if (read_req && ready)
    begin
      due = cyc + 1 + $urandom_range(6, 2);
      // beats come back in order
      if (due <= last_due)
        due = last_due + 1;
      for (int unsigned b = 0; b < mem_test_pkg::BURST_LEN; b++)
      begin
        key  = mem_key(addr, b);
        word = mem.exists(key) ? mem[key] : '0;
        due_q.push_back(due + b);
        data_q.push_back(word);
      end
      last_due = due + mem_test_pkg::BURST_LEN - 1;
    end
  endtask

  task automatic drive_outputs();
    if (!reset_n)
    begin
      ready       = 1'b0;
      rdata_valid = 1'b0;
    end
    else
    begin
      // ready low about one cycle in four
      ready = ($urandom_range(3, 0) != 0);
      if (due_q.size() > 0 && due_q[0] <= cyc)
      begin
        rdata = data_q.pop_front();
        due_q.delete(0);
        // flip every bit of lane 2 on the chosen beat
        if (int'(rd_beats_out) == CORRUPT_BEAT)
          rdata = rdata ^ 32'h00ff_0000;
        rdata_valid = 1'b1;
        rd_beats_out++;
      end
      else
      begin
        rdata_valid = 1'b0;
      end
    end
  endtask

  initial
  begin
    ready        = 1'b0;
    rdata_valid  = 1'b0;
    rdata        = '0;
    cyc          = 0;
    wr_beat      = 0;
    rd_beats_out = 0;
    last_due     = 0;
    forever
    begin
      @(negedge clk);
      if (reset_n)
        accept_requests();
      @(posedge clk);
      #1;
      cyc++;
      drive_outputs();
    end
  end

endmodule

// File: design/mem_test_driver.sv
// ddr2 local port traffic driver

`timescale 1ns/1ps

module mem_test_driver #(
  parameter int MAX_COL  = 16,
  parameter int MAX_ROW  = 3,
  parameter int MAX_BANK = 3,
  parameter int COL_STEP = 4
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     local_ready,
  input  logic                     local_rdata_valid,
  input  mem_test_pkg::data_t      local_rdata,
  output logic                     local_write_req,
  output logic                     local_read_req,
  output logic                     local_burstbegin,
  output mem_test_pkg::bank_t      local_bank_addr,
  output mem_test_pkg::row_t       local_row_addr,
  output mem_test_pkg::col_t       local_col_addr,
  output logic                     local_cs_addr,
  output logic [2:0]               local_size,
  output mem_test_pkg::lane_mask_t local_be,
  output mem_test_pkg::data_t      local_wdata,
  output mem_test_pkg::lane_mask_t pnf_per_byte,
  output logic                     pnf_persist,
  output logic                     test_complete
);

  logic                    addr_step;
  logic                    addr_clear;
  logic                    capture;
  logic                    reload;
  logic                    at_last;
  logic                    advance;
  mem_test_pkg::mem_addr_t addr;
  mem_test_pkg::data_t     pattern;

  // pattern steps on each write beat out and each read beat in
  assign advance = (local_write_req && local_ready) || local_rdata_valid;

  // ------------------------------------------------------------------------
  // local port fields and tie-offs
  // ------------------------------------------------------------------------
  assign local_bank_addr = addr.bank;
  assign local_row_addr  = addr.row;
  assign local_col_addr  = addr.col;
  assign local_cs_addr   = 1'b0;
  assign local_size      = 3'(mem_test_pkg::BURST_LEN);
  assign local_be        = '1;
  assign local_wdata     = pattern;

  test_ctrl #(
    .MAX_COL  (MAX_COL),
    .MAX_ROW  (MAX_ROW),
    .MAX_BANK (MAX_BANK),
    .COL_STEP (COL_STEP)
  ) i_test_ctrl (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .at_last           (at_last),
    .write_req         (local_write_req),
    .read_req          (local_read_req),
    .burst_begin       (local_burstbegin),
    .addr_step         (addr_step),
    .addr_clear        (addr_clear),
    .capture           (capture),
    .reload            (reload),
    .test_complete     (test_complete)
  );

  seq_addr_gen #(
    .MAX_COL  (MAX_COL),
    .MAX_ROW  (MAX_ROW),
    .MAX_BANK (MAX_BANK),
    .COL_STEP (COL_STEP)
  ) i_seq_addr_gen (
    .clk        (clk),
    .reset_n    (reset_n),
    .addr_step  (addr_step),
    .addr_clear (addr_clear),
    .addr       (addr),
    .at_last    (at_last)
  );

  // same generator feeds write data and expected read data
  pattern_gen i_pattern_gen (
    .clk     (clk),
    .reset_n (reset_n),
    .advance (advance),
    .capture (capture),
    .reload  (reload),
    .data    (pattern)
  );

  rdata_checker i_rdata_checker (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_rdata_valid (local_rdata_valid),
    .local_rdata       (local_rdata),
    .expected          (pattern),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist)
  );

endmodule

// File: design/rdata_checker.sv
// read data lane checker

`timescale 1ns/1ps

module rdata_checker (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     local_rdata_valid,
  input  mem_test_pkg::data_t      local_rdata,
  input  mem_test_pkg::data_t      expected,
  output mem_test_pkg::lane_mask_t pnf_per_byte,
  output logic                     pnf_persist
);

  mem_test_pkg::lane_mask_t lane_match;
  mem_test_pkg::lane_mask_t match_q1;
  mem_test_pkg::lane_mask_t match_q2;
  logic                     valid_q1;
  logic                     valid_q2;
  logic                     first_seen;

  // per lane equality
  always_comb
  begin
    for (int k = 0; k < mem_test_pkg::LANES; k++)
    begin
      lane_match[k] = local_rdata[k*mem_test_pkg::LANE_W +: mem_test_pkg::LANE_W] ==
                      expected[k*mem_test_pkg::LANE_W +: mem_test_pkg::LANE_W];
    end
  end

  // ------------------------------------------------------------------------
  // compare pipeline, results land on the third edge after a beat
  // ------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    match_q1 <= lane_match;
    match_q2 <= match_q1;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      valid_q1     <= 1'b0;
      valid_q2     <= 1'b0;
      first_seen   <= 1'b0;
      pnf_per_byte <= '1;
      pnf_persist  <= 1'b0;
    end
    else
    begin
      valid_q1 <= local_rdata_valid;
      valid_q2 <= valid_q1;
      if (valid_q2)
      begin
        pnf_per_byte <= match_q2;
        // any miss keeps this low until reset
        pnf_persist  <= (&match_q2) && (pnf_persist || !first_seen);
        first_seen   <= 1'b1;
      end
    end
  end

endmodule

// File: design/test_ctrl.sv
// write/read pass controller

`timescale 1ns/1ps

module test_ctrl #(
  parameter int MAX_COL  = 16,
  parameter int MAX_ROW  = 3,
  parameter int MAX_BANK = 3,
  parameter int COL_STEP = 4
) (
  input  logic clk,
  input  logic reset_n,
  input  logic local_ready,
  input  logic local_rdata_valid,
  input  logic at_last,
  output logic write_req,
  output logic read_req,
  output logic burst_begin,
  output logic addr_step,
  output logic addr_clear,
  output logic capture,
  output logic reload,
  output logic test_complete
);

  // bursts per pass, sizes the outstanding read counter
  localparam int BURSTS = (MAX_COL / COL_STEP + 1) * (MAX_ROW + 1) * (MAX_BANK + 1);
  localparam int PEND_W = $clog2(BURSTS * mem_test_pkg::BURST_LEN + 1);
  localparam int BEAT_W = $clog2(mem_test_pkg::BURST_LEN + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_FIRST,
    ST_WR_BEAT,
    ST_RD_CMD,
    ST_RD_DRAIN,
    ST_DONE
  } state_t;

  state_t            state;
  logic [BEAT_W-1:0] beat_cnt;
  logic [PEND_W-1:0] rd_pending;
  logic              wr_accept;
  logic              rd_accept;
  logic              burst_end;

  // ------------------------------------------------------------------------
  // request decode, held steady by the state while ready is low
  // ------------------------------------------------------------------------
  assign write_req   = (state == ST_WR_FIRST) || (state == ST_WR_BEAT);
  assign read_req    = (state == ST_RD_CMD);
  assign burst_begin = (state == ST_WR_FIRST) || (state == ST_RD_CMD);

  assign wr_accept = write_req && local_ready;
  assign rd_accept = read_req && local_ready;
  assign burst_end = wr_accept && (beat_cnt == BEAT_W'(mem_test_pkg::BURST_LEN - 1));

  assign addr_step     = burst_end || rd_accept;
  assign addr_clear    = (state == ST_IDLE);
  assign capture       = (state == ST_IDLE);
  // rewind the pattern as the final write beat goes out
  assign reload        = burst_end && at_last;
  assign test_complete = (state == ST_DONE);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state    <= ST_IDLE;
      beat_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          state <= ST_WR_FIRST;
        ST_WR_FIRST, ST_WR_BEAT:
        begin
          if (burst_end)
          begin
            beat_cnt <= '0;
            state    <= at_last ? ST_RD_CMD : ST_WR_FIRST;
          end
          else if (wr_accept)
          begin
            beat_cnt <= beat_cnt + 1'b1;
            state    <= ST_WR_BEAT;
          end
        end
        ST_RD_CMD:
        begin
          if (rd_accept && at_last)
            state <= ST_RD_DRAIN;
        end
        ST_RD_DRAIN:
        begin
          if (rd_pending == '0)
            state <= ST_DONE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // read beats still owed by the controller
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_pending <= '0;
    end
    else
    begin
      case ({rd_accept, local_rdata_valid})
        2'b10:   rd_pending <= rd_pending + PEND_W'(mem_test_pkg::BURST_LEN);
        2'b11:   rd_pending <= rd_pending + PEND_W'(mem_test_pkg::BURST_LEN - 1);
        2'b01:   rd_pending <= rd_pending - 1'b1;
        default: rd_pending <= rd_pending;
      endcase
    end
  end

endmodule

// File: design/seq_addr_gen.sv
// sequential burst address counter

`timescale 1ns/1ps

module seq_addr_gen #(
  parameter int MAX_COL  = 16,
  parameter int MAX_ROW  = 3,
  parameter int MAX_BANK = 3,
  parameter int COL_STEP = 4
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    addr_step,
  input  logic                    addr_clear,
  output mem_test_pkg::mem_addr_t addr,
  output logic                    at_last
);

  localparam mem_test_pkg::mem_addr_t LAST_ADDR = '{
    bank: mem_test_pkg::bank_t'(MAX_BANK),
    row:  mem_test_pkg::row_t'(MAX_ROW),
    col:  mem_test_pkg::col_t'(MAX_COL)
  };

  assign at_last = (addr == LAST_ADDR);

  // ------------------------------------------------------------------------
  // col steps first, then carries into row and bank
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      addr <= '0;
    end
    else if (addr_clear)
    begin
      addr <= '0;
    end
    else if (addr_step)
    begin
      if (addr.col >= mem_test_pkg::col_t'(MAX_COL))
      begin
        addr.col <= '0;
        if (addr.row >= mem_test_pkg::row_t'(MAX_ROW))
        begin
          addr.row <= '0;
          // bank wrap closes the whole range
          if (addr.bank >= mem_test_pkg::bank_t'(MAX_BANK))
            addr.bank <= '0;
          else
            addr.bank <= addr.bank + 1'b1;
        end
        else
        begin
          addr.row <= addr.row + 1'b1;
        end
      end
      else
      begin
        addr.col <= addr.col + mem_test_pkg::col_t'(COL_STEP);
      end
    end
  end

endmodule

// File: design/pattern_gen.sv
// lane pattern generator

`timescale 1ns/1ps

module pattern_gen (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                advance,
  input  logic                capture,
  input  logic                reload,
  output mem_test_pkg::data_t data
);

  // word seen at the start of the write phase
  mem_test_pkg::data_t start_word;

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      start_word <= data;
    end
  end

  // ------------------------------------------------------------------------
  // one lfsr per byte lane, seeds 1, 11, 21, 31
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < mem_test_pkg::LANES; i++)
  begin : g_lane
    lfsr8 #(
      .SEED (8'(1 + 10 * i))
    ) i_lfsr8 (
      .clk     (clk),
      .reset_n (reset_n),
      .advance (advance),
      .load    (reload),
      .ldata   (start_word[i*mem_test_pkg::LANE_W +: mem_test_pkg::LANE_W]),
      .q       (data[i*mem_test_pkg::LANE_W +: mem_test_pkg::LANE_W])
    );
  end

endmodule

// File: design/lfsr8.sv
// 8-bit lfsr lane

`timescale 1ns/1ps

module lfsr8 #(
  parameter logic [7:0] SEED = 8'd1
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       advance,
  input  logic       load,
  input  logic [7:0] ldata,
  output logic [7:0] q
);

  logic feedback;

  // taps 7,5,4,3, maximal length for a non-zero seed
  assign feedback = q[7] ^ q[5] ^ q[4] ^ q[3];

  // load wins over a shift in the same cycle
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      q <= SEED;
    end
    else if (load)
    begin
      q <= ldata;
    end
    else if (advance)
    begin
      q <= {q[6:0], feedback};
    end
  end

endmodule

// File: design/mem_test_pkg.sv
// memory test shared definitions

package mem_test_pkg;

  // ------------------------------------------------------------------------
  // local port geometry
  // ------------------------------------------------------------------------
  localparam int DATA_W    = 32;
  localparam int LANES     = 4;
  localparam int LANE_W    = DATA_W / LANES;
  localparam int BURST_LEN = 2;

  // address field widths
  localparam int COL_W  = 10;
  localparam int ROW_W  = 13;
  localparam int BANK_W = 2;

  // ------------------------------------------------------------------------
  // field types
  // ------------------------------------------------------------------------
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [COL_W-1:0]  col_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [BANK_W-1:0] bank_t;

  // one bit per byte lane
  typedef logic [LANES-1:0] lane_mask_t;

  // full burst address, bank in the top bits
  typedef struct packed {
    bank_t bank;
    row_t  row;
    col_t  col;
  } mem_addr_t;

endpackage
